//--- Makefile
BUILD = obj_dir
LOG   = sim.log

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f list.f \
		--top-module sphere_render_tb -Mdir $(BUILD) -o sim

run: compile
	./$(BUILD)/sim +verilator+error+limit+1000 | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

.PHONY: all compile run clean

//--- common/fixed_pkg.sv
`default_nettype none

package fixed_pkg;

    localparam int FRAC_BITS = 24;

    // Signed Q8.24.
    typedef logic signed [31:0] fp;

    typedef struct packed {
        logic [7:0]  int_part;
        logic [23:0] frac;
    } fp_fields_t;

    // Same word, seen as a number or as its fields.
    typedef union packed {
        fp          value;
        fp_fields_t fields;
    } fp_word_u;

    function automatic fp fp_mul(input fp a, input fp b);
        logic signed [63:0] prod;
        prod = a * b;
        return fp'(prod >>> FRAC_BITS);
    endfunction

    function automatic fp vec3_dot(
        input fp ax,
        input fp ay,
        input fp az,
        input fp bx,
        input fp by,
        input fp bz
    );
        return fp_mul(ax, bx) + fp_mul(ay, by) + fp_mul(az, bz);
    endfunction

endpackage

`default_nettype wire

//--- common/render_cfg.svh
`ifndef RENDER_CFG_SVH
`define RENDER_CFG_SVH

// Image size in pixels.
`define IMG_W 32
`define IMG_H 32

// Radius 8 pixels, squared.
`define SPHERE_R2 64

// Pixel offset to Q8.24 normal, i.e. dx / 8.
`define NORM_SHIFT 21

`define FP_HALF 32'h00800000 // 0.5

// Material colours, Q8.24.
`define AMB_R  32'h00333333 // 0.2
`define AMB_G  32'h004ccccd // 0.3
`define AMB_B  32'h00666666 // 0.4
`define DIFF_R 32'h00cccccd // 0.8
`define DIFF_G 32'h00b33333 // 0.7
`define DIFF_B 32'h00800000 // 0.5

`endif

//--- common/render_pkg.sv
`default_nettype none

package render_pkg;

    // Controller states.
    typedef enum logic [2:0] {
        IDLE,
        TEST,
        ROOT,
        ISSUE,
        DRAIN,
        DONE
    } ctrl_state_e;

    typedef logic [4:0] coord_t; // 0 to 31.

endpackage

`default_nettype wire

//--- hdl/isqrt_unit.sv
`default_nettype none
`timescale 1ns/1ns

module isqrt_unit (
    input  logic         clk,
    input  logic         rst,
    input  logic         sqrt_start,
    input  logic [47:0]  radicand,
    output fixed_pkg::fp root,
    output logic         done
);

    logic [47:0] rad_q, rad_src;
    logic [25:0] rem_q, rem_src;
    logic [23:0] root_q, root_src;
    logic [27:0] trial;
    logic [4:0]  cnt;
    logic        run;

    // First bit pair is taken on the start edge itself.
    always_comb begin
        rad_src  = sqrt_start ? radicand : rad_q;
        rem_src  = sqrt_start ? '0 : rem_q;
        root_src = sqrt_start ? '0 : root_q;
        trial    = {rem_src, rad_src[47:46]} - {2'b00, root_src, 2'b01};
    end

    always_ff @(posedge clk) begin
        if (sqrt_start || run) begin
            rad_q  <= rad_src << 2;
            root_q <= {root_src[22:0], ~trial[27]};
            rem_q  <= trial[27] ? {rem_src[23:0], rad_src[47:46]} : trial[25:0]; // Restore.
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            run  <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= run && (cnt == 5'd1);
            if (sqrt_start) begin
                run <= 1'b1;
                cnt <= 5'd23; // Iterations left.
            end else if (run) begin
                cnt <= cnt - 1'b1;
                run <= (cnt != 5'd1);
            end
        end
    end

    assign root = {8'd0, root_q}; // Floor root, Q8.24.

endmodule

`default_nettype wire

//--- hdl/pixel_counter.sv
`default_nettype none
`timescale 1ns/1ns
`include "render_cfg.svh"

module pixel_counter (
    input  logic               clk,
    input  logic               rst,
    input  logic               clear,
    input  logic               step,
    output render_pkg::coord_t pix_x,
    output render_pkg::coord_t pix_y,
    output logic               last
);

    always_ff @(posedge clk) begin
        if (!rst || clear) begin
            pix_x <= '0;
            pix_y <= '0;
        end else if (step) begin
            if (pix_x == render_pkg::coord_t'(`IMG_W - 1)) begin
                pix_x <= '0;
                pix_y <= pix_y + 1'b1; // Wraps after the last row.
            end else begin
                pix_x <= pix_x + 1'b1;
            end
        end
    end

    assign last = (pix_x == render_pkg::coord_t'(`IMG_W - 1))
               && (pix_y == render_pkg::coord_t'(`IMG_H - 1));

endmodule

`default_nettype wire

//--- hdl/render_ctrl.sv
`default_nettype none
`timescale 1ns/1ns

module render_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic last,
    input  logic hit,
    input  logic done,
    output logic clear,
    output logic step,
    output logic load,
    output logic sqrt_start,
    output logic valid_in,
    output logic busy,
    output logic frame_done
);

    localparam int DRAIN_CYCLES = 4; // Shading latency.

    render_pkg::ctrl_state_e state, state_next;
    logic       tested; // First ROOT cycle, hit is fresh.
    logic [1:0] drain_cnt;

    always_comb begin
        state_next = state;
        case (state)
            render_pkg::IDLE:  if (start) state_next = render_pkg::TEST;
            render_pkg::TEST:  state_next = render_pkg::ROOT;
            render_pkg::ROOT: begin
                if (tested && !hit)
                    state_next = render_pkg::ISSUE; // Miss needs no root.
                else if (done)
                    state_next = render_pkg::ISSUE;
            end
            render_pkg::ISSUE: state_next = last ? render_pkg::DRAIN : render_pkg::TEST;
            render_pkg::DRAIN: if (drain_cnt == '0) state_next = render_pkg::DONE;
            render_pkg::DONE:  state_next = render_pkg::IDLE;
            default:           state_next = render_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state     <= render_pkg::IDLE;
            tested    <= 1'b0;
            drain_cnt <= '0;
        end else begin
            state  <= state_next;
            tested <= (state == render_pkg::TEST);
            if (state == render_pkg::ISSUE)
                drain_cnt <= 2'(DRAIN_CYCLES - 1);
            else if (state == render_pkg::DRAIN)
                drain_cnt <= drain_cnt - 1'b1;
        end
    end

    assign clear      = (state == render_pkg::IDLE) && start;
    assign load       = (state == render_pkg::TEST);
    assign sqrt_start = (state == render_pkg::ROOT) && tested && hit;
    assign valid_in   = (state == render_pkg::ISSUE);
    assign step       = valid_in;
    assign busy       = (state != render_pkg::IDLE) && (state != render_pkg::DONE);
    assign frame_done = (state == render_pkg::DONE);

endmodule

`default_nettype wire

//--- hdl/sphere_hit.sv
`default_nettype none
`timescale 1ns/1ns
`include "render_cfg.svh"

module sphere_hit (
    input  logic               clk,
    input  logic               rst,
    input  logic               load,
    input  render_pkg::coord_t pix_x,
    input  render_pkg::coord_t pix_y,
    input  render_pkg::coord_t center_x,
    input  render_pkg::coord_t center_y,
    output logic               hit,
    output fixed_pkg::fp       norm_x,
    output fixed_pkg::fp       norm_y,
    output logic [47:0]        radicand
);

    logic signed [11:0] dx, dy;
    logic signed [11:0] dist2;
    logic signed [11:0] margin;
    logic               hit_c;
    logic [47:0]        rad_c;

    assign dx     = $signed({7'd0, pix_x}) - $signed({7'd0, center_x});
    assign dy     = $signed({7'd0, pix_y}) - $signed({7'd0, center_y});
    assign dist2  = dx * dx + dy * dy;
    assign hit_c  = (dist2 <= `SPHERE_R2);
    assign margin = `SPHERE_R2 - dist2;
    // At the centre R2 << 42 is 2^48, so clip to all ones.
    assign rad_c  = (dist2 == '0) ? '1 : 48'(margin) << (2 * `NORM_SHIFT);

    always_ff @(posedge clk) begin
        if (!rst)
            hit <= 1'b0;
        else if (load)
            hit <= hit_c;
    end

    always_ff @(posedge clk) begin
        if (load) begin
            norm_x   <= fixed_pkg::fp'(dx) <<< `NORM_SHIFT;
            norm_y   <= fixed_pkg::fp'(dy) <<< `NORM_SHIFT;
            radicand <= hit_c ? rad_c : '0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/sphere_render.sv
`default_nettype none
`timescale 1ns/1ns

module sphere_render (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  render_pkg::coord_t center_x,
    input  render_pkg::coord_t center_y,
    input  fixed_pkg::fp       light_x,
    input  fixed_pkg::fp       light_y,
    input  fixed_pkg::fp       light_z,
    output logic               busy,
    output logic               frame_done,
    output logic               valid_out,
    output logic [23:0]        shade_out
);

    render_pkg::coord_t pix_x, pix_y;
    fixed_pkg::fp       norm_x, norm_y, root;
    logic [47:0]        radicand;
    logic               clear, step, last, load, hit;
    logic               sqrt_start, sqrt_done, valid_in;

    render_ctrl ctrl_i (
        .clk(clk), .rst(rst), .start(start), .last(last), .hit(hit), .done(sqrt_done),
        .clear(clear), .step(step), .load(load), .sqrt_start(sqrt_start),
        .valid_in(valid_in), .busy(busy), .frame_done(frame_done)
    );

    pixel_counter counter_i (
        .clk(clk), .rst(rst), .clear(clear), .step(step),
        .pix_x(pix_x), .pix_y(pix_y), .last(last)
    );

    sphere_hit sphere_hit_i (
        .clk(clk), .rst(rst), .load(load), .pix_x(pix_x), .pix_y(pix_y),
        .center_x(center_x), .center_y(center_y), .hit(hit),
        .norm_x(norm_x), .norm_y(norm_y), .radicand(radicand)
    );

    isqrt_unit isqrt_i (
        .clk(clk), .rst(rst), .sqrt_start(sqrt_start), .radicand(radicand),
        .root(root), .done(sqrt_done)
    );

    shading shading_i (
        .clk(clk), .rst(rst), .valid_in(valid_in), .hit_in(hit),
        .normal_x(norm_x), .normal_y(norm_y), .normal_z(root),
        .light_x(light_x), .light_y(light_y), .light_z(light_z),
        .shade_out(shade_out), .valid_out(valid_out)
    );

endmodule

`default_nettype wire

//--- list.f
+incdir+common
common/fixed_pkg.sv
common/render_pkg.sv
hdl/pixel_counter.sv
hdl/render_ctrl.sv
hdl/sphere_hit.sv
hdl/isqrt_unit.sv
shading/shading.sv
hdl/sphere_render.sv
verif/tb_clk.sv
verif/sphere_render_assert.sv
verif/sphere_render_tb.sv

//--- shading/shading.sv
`default_nettype none
`timescale 1ns/1ns
`include "render_cfg.svh"

module shading (
    input  logic         clk,
    input  logic         rst,
    input  logic         valid_in,
    input  logic         hit_in,
    input  fixed_pkg::fp normal_x,
    input  fixed_pkg::fp normal_y,
    input  fixed_pkg::fp normal_z,
    input  fixed_pkg::fp light_x,
    input  fixed_pkg::fp light_y,
    input  fixed_pkg::fp light_z,
    output logic [23:0]  shade_out,
    output logic         valid_out
);

    fixed_pkg::fp        dot_nl, amb_comp;
    fixed_pkg::fp        diffuse, ambient;
    fixed_pkg::fp        amb_r, amb_g, amb_b;
    fixed_pkg::fp        diff_r, diff_g, diff_b;
    fixed_pkg::fp_word_u sum_r, sum_g, sum_b;
    logic                valid_1, valid_2, valid_3;
    logic                hit_1, hit_2, hit_3;

    // Valid and hit ride along with the data.
    always_ff @(posedge clk) begin
        if (!rst) begin
            valid_1   <= 1'b0;
            valid_2   <= 1'b0;
            valid_3   <= 1'b0;
            valid_out <= 1'b0;
            hit_1     <= 1'b0;
            hit_2     <= 1'b0;
            hit_3     <= 1'b0;
        end else begin
            valid_1   <= valid_in;
            hit_1     <= valid_in && hit_in;
            valid_2   <= valid_1;
            hit_2     <= hit_1;
            valid_3   <= valid_2;
            hit_3     <= hit_2;
            valid_out <= valid_3;
        end
    end

    always_ff @(posedge clk) begin
        dot_nl   <= fixed_pkg::vec3_dot(normal_x, normal_y, normal_z,
                                        light_x, light_y, light_z);
        amb_comp <= (normal_y < 0) ? '0 : normal_y; // Upward facing only.

        diffuse  <= (dot_nl < 0) ? '0 : dot_nl;
        ambient  <= `FP_HALF + fixed_pkg::fp_mul(`FP_HALF, amb_comp);

        amb_r    <= fixed_pkg::fp_mul(ambient, `AMB_R);
        amb_g    <= fixed_pkg::fp_mul(ambient, `AMB_G);
        amb_b    <= fixed_pkg::fp_mul(ambient, `AMB_B);
        diff_r   <= fixed_pkg::fp_mul(diffuse, `DIFF_R);
        diff_g   <= fixed_pkg::fp_mul(diffuse, `DIFF_G);
        diff_b   <= fixed_pkg::fp_mul(diffuse, `DIFF_B);
    end

    always_comb begin
        sum_r.value = amb_r + diff_r;
        sum_g.value = amb_g + diff_g;
        sum_b.value = amb_b + diff_b;
    end

    // Colour byte is the top of the fraction; 1.0 and up wraps.
    always_ff @(posedge clk) begin
        shade_out <= hit_3 ? {sum_r.fields.frac[23:16],
                              sum_g.fields.frac[23:16],
                              sum_b.fields.frac[23:16]} : '0;
    end

endmodule

`default_nettype wire

//--- verif/sphere_render_assert.sv
`default_nettype none
`timescale 1ns/1ns

module sphere_render_assert (
    input logic        clk,
    input logic        rst,
    input logic        busy,
    input logic        frame_done,
    input logic        valid_in,
    input logic        hit,
    input logic        valid_out,
    input logic [23:0] shade_out,
    input logic        sqrt_start,
    input logic        sqrt_done
);

    int fail_count = 0; // Failures seen so far.

    frame_done_pulse: assert property (@(posedge clk) disable iff (!rst)
        frame_done |=> !frame_done)
        else begin
            $error("frame_done held high for more than one cycle");
            fail_count++;
        end

    busy_fall: assert property (@(posedge clk) disable iff (!rst)
        $fell(busy) |-> frame_done)
        else begin
            $error("busy fell without frame_done");
            fail_count++;
        end

    // A missed pixel leaves shading as a zero word.
    miss_is_zero: assert property (@(posedge clk) disable iff (!rst)
        (valid_in && !hit) |-> ##4 (valid_out && shade_out == '0))
        else begin
            $error("missed pixel did not come out as a zero word");
            fail_count++;
        end

    root_latency: assert property (@(posedge clk) disable iff (!rst)
        sqrt_start |-> ##24 sqrt_done)
        else begin
            $error("square root done not 24 cycles after start");
            fail_count++;
        end

endmodule

`default_nettype wire

//--- verif/sphere_render_tb.sv
`default_nettype none
`timescale 1ns/1ns
`include "render_cfg.svh"

module sphere_render_tb;

    localparam int     NUM_FRAMES  = 10;
    localparam int     FRAME_LIMIT = 1024 * 32; // Cycles.
    localparam longint WATCHDOG_NS = longint'(NUM_FRAMES) * FRAME_LIMIT * 40 + 200000;

    logic               clk, rst, start;
    render_pkg::coord_t center_x, center_y;
    fixed_pkg::fp       light_x, light_y, light_z;
    logic               busy, frame_done, valid_out;
    logic [23:0]        shade_out;

    logic [31:0] lfsr = 32'h3a34ba30;
    logic [23:0] expected[$];
    int          errors = 0;
    int          pixels = 0;
    int          frames = 0;
    int          frame_pixels = 0;

    tb_clk #(.PERIOD(40)) clk_i (.clk(clk));

    sphere_render dut_i (.*);

    bind sphere_render sphere_render_assert assert_i (
        .clk(clk), .rst(rst), .busy(busy), .frame_done(frame_done),
        .valid_in(valid_in), .hit(hit), .valid_out(valid_out), .shade_out(shade_out),
        .sqrt_start(sqrt_start), .sqrt_done(sqrt_done)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic fixed_pkg::fp q24_mul(input fixed_pkg::fp a, input fixed_pkg::fp b);
        logic signed [63:0] p;
        p = 64'(a) * 64'(b);
        return p[55:24];
    endfunction

    function automatic logic [31:0] floor_sqrt(input logic [63:0] v);
        logic [31:0] lo, hi, mid;
        lo = 0;
        hi = 32'h0100_0000;
        while (lo < hi) begin
            mid = (lo + hi + 1) >> 1;
            if (64'(mid) * 64'(mid) <= v)
                lo = mid;
            else
                hi = mid - 1;
        end
        return lo;
    endfunction

    function automatic logic [23:0] pixel_word(input int cx, input int cy, input int px,
                                               input int py, input fixed_pkg::fp lx,
                                               input fixed_pkg::fp ly, input fixed_pkg::fp lz);
        int           dx, dy, d2;
        logic [63:0]  rad;
        fixed_pkg::fp nx, ny, nz, dot, amb, dif, r, g, b;
        dx = px - cx;
        dy = py - cy;
        d2 = dx * dx + dy * dy;
        if (d2 > `SPHERE_R2)
            return 24'h0;
        nx  = dx * (1 << `NORM_SHIFT);
        ny  = dy * (1 << `NORM_SHIFT);
        rad = 64'(`SPHERE_R2 - d2) << (2 * `NORM_SHIFT);
        if (rad > 64'hffff_ffff_ffff)
            rad = 64'hffff_ffff_ffff; // Radicand is 48 bits wide.
        nz  = fixed_pkg::fp'(floor_sqrt(rad));
        dot = q24_mul(nx, lx) + q24_mul(ny, ly) + q24_mul(nz, lz);
        amb = `FP_HALF + q24_mul(`FP_HALF, (ny < 0) ? '0 : ny);
        dif = (dot < 0) ? '0 : dot;
        r   = q24_mul(amb, `AMB_R) + q24_mul(dif, `DIFF_R);
        g   = q24_mul(amb, `AMB_G) + q24_mul(dif, `DIFF_G);
        b   = q24_mul(amb, `AMB_B) + q24_mul(dif, `DIFF_B);
        return {r[23:16], g[23:16], b[23:16]};
    endfunction

    task automatic drive_next();
        @(posedge clk);
        #5;
    endtask

    task automatic random_scene(output int cx, output int cy, output fixed_pkg::fp lx,
                                output fixed_pkg::fp ly, output fixed_pkg::fp lz);
        logic [31:0] v;
        draw_bits(5, v);
        cx = 4 + int'(v % 24);
        draw_bits(5, v);
        cy = 4 + int'(v % 24);
        draw_bits(25, v);
        lx = v - 32'h0100_0000; // -1.0 up to just under 1.0.
        draw_bits(25, v);
        ly = v - 32'h0100_0000;
        draw_bits(25, v);
        lz = v - 32'h0100_0000;
    endtask

    task automatic start_frame(input int cx, input int cy, input fixed_pkg::fp lx,
                               input fixed_pkg::fp ly, input fixed_pkg::fp lz);
        drive_next();
        center_x = render_pkg::coord_t'(cx);
        center_y = render_pkg::coord_t'(cy);
        light_x  = lx;
        light_y  = ly;
        light_z  = lz;
        for (int y = 0; y < `IMG_H; y++)
            for (int x = 0; x < `IMG_W; x++)
                expected.push_back(pixel_word(cx, cy, x, y, lx, ly, lz));
        start = 1'b1;
        drive_next();
        start = 1'b0;
    endtask

    task automatic render_frame(input int cx, input int cy, input fixed_pkg::fp lx,
                                input fixed_pkg::fp ly, input fixed_pkg::fp lz,
                                input int stray_start);
        int n;
        start_frame(cx, cy, lx, ly, lz);
        if (stray_start > 0) begin
            repeat (stray_start) drive_next();
            start = 1'b1; // Ignored while busy.
            drive_next();
            start = 1'b0;
        end
        n = 0;
        do begin
            @(negedge clk);
            n++;
            check_value("busy", busy, frame_done ? 32'd0 : 32'd1); // Falls with frame_done.
        end while (!frame_done && n < FRAME_LIMIT);
        if (!frame_done) begin
            errors++;
            $display("frame_done did not arrive within %0d cycles", FRAME_LIMIT);
        end
    endtask

    always @(negedge clk) begin
        if (rst && valid_out) begin
            pixels++;
            frame_pixels++;
            if (expected.size() == 0) begin
                errors++;
                $display("valid_out at %0t ns with no pixel left in the model", $time);
            end else begin
                check_value("shade_out", 32'(shade_out), 32'(expected.pop_front()));
            end
        end
        if (rst && frame_done) begin
            frames++;
            check_value("pixels_per_frame", frame_pixels, 1024);
            frame_pixels = 0;
        end
    end

    initial begin
        int           cx, cy;
        fixed_pkg::fp lx, ly, lz;
        rst      = 1'b0;
        start    = 1'b0;
        center_x = '0;
        center_y = '0;
        light_x  = '0;
        light_y  = '0;
        light_z  = '0;
        repeat (8) @(posedge clk);
        #5 rst = 1'b1;
        @(negedge clk);
        check_value("busy", busy, 0);
        check_value("frame_done", frame_done, 0);
        check_value("valid_out", valid_out, 0);
        check_value("sqrt_start", dut_i.sqrt_start, 0);
        check_value("sqrt_done", dut_i.sqrt_done, 0);

        render_frame(16, 16, '0, '0, 32'h0100_0000, 0); // Light along +z.
        render_frame(4, 27, 32'h0080_0000, 32'hff80_0000, 32'h00b5_0000, 0);
        render_frame(12, 19, '0, '0, 32'hff00_0000, 0); // From behind.

        for (int f = 0; f < 5; f++) begin
            random_scene(cx, cy, lx, ly, lz);
            render_frame(cx, cy, lx, ly, lz, (f == 2) ? 300 : 0);
        end

        // Reset in the middle of a frame.
        random_scene(cx, cy, lx, ly, lz);
        start_frame(cx, cy, lx, ly, lz);
        repeat (1500) drive_next();
        rst = 1'b0;
        expected.delete();
        drive_next();
        @(negedge clk);
        check_value("busy", busy, 0);
        check_value("valid_out", valid_out, 0);
        repeat (7) drive_next();
        rst          = 1'b1;
        frame_pixels = 0;
        render_frame(cx, cy, lx, ly, lz, 0);

        repeat (4) drive_next();
        check_value("leftover_pixels", expected.size(), 0);
        $display("errors=%0d assertion_failures=%0d pixels=%0d frames=%0d",
                 errors, dut_i.assert_i.fail_count, pixels, frames);
        if (errors == 0 && dut_i.assert_i.fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired at %0t ns before the tests finished", $time);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/tb_clk.sv
`default_nettype none
`timescale 1ns/1ns

module tb_clk #(
    parameter int PERIOD = 40
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire
